//--- common/exe_pkg.sv
package exe_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] pc_t;
    // register 0 always reads zero
    typedef logic [4:0]  reg_addr_t;

    // shifts use b[4:0], lui passes b through
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_t;

    typedef enum logic [3:0] {
        BR_BEQ  = 4'd0,
        BR_BNE  = 4'd1,
        BR_BLT  = 4'd2,
        BR_BGE  = 4'd3,
        BR_BLTU = 4'd4,
        BR_BGEU = 4'd5,
        BR_B    = 4'd6,
        BR_BL   = 4'd7,
        BR_JIRL = 4'd8
    } br_op_t;

    // low word, signed high word, unsigned high word
    typedef enum logic [1:0] {
        MUL_MUL   = 2'd0,
        MUL_MULH  = 2'd1,
        MUL_MULHU = 2'd2
    } mul_op_t;

    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_BR  = 2'd1,
        UNIT_MUL = 2'd2
    } unit_t;

    // return address of bl and jirl is pc + link_offset
    localparam data_t link_offset = 32'd4;

endpackage

//--- files.f
common/exe_pkg.sv
verilog/alu.sv
verilog/operand_forward.sv
verilog/branch_unit.sv
mul/mul_pipe.sv
verilog/issue_hazard.sv
verilog/exe_stage.sv
verif/exe_stage_tb.sv

//--- mul/mul_pipe.sv
module mul_pipe (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  exe_pkg::mul_op_t   op,
    input  exe_pkg::reg_addr_t rd,
    input  exe_pkg::data_t     a,
    input  exe_pkg::data_t     b,
    output logic               mid_en,
    output exe_pkg::reg_addr_t mid_rd,
    output logic               out_en,
    output exe_pkg::reg_addr_t out_rd,
    output exe_pkg::data_t     result
);

    logic [31:0]      pp_ll;
    logic [31:0]      pp_lh;
    logic [31:0]      pp_hl;
    logic [31:0]      pp_hh;
    exe_pkg::data_t   corr;
    logic [31:0]      pp_ll_q;
    logic [31:0]      pp_lh_q;
    logic [31:0]      pp_hl_q;
    logic [31:0]      pp_hh_q;
    exe_pkg::data_t   corr_q;
    exe_pkg::mul_op_t op_q;
    logic [63:0]      sum;
    exe_pkg::data_t   high;

    // four unsigned 16x16 products
    assign pp_ll = 32'(a[15:0]) * 32'(b[15:0]);
    assign pp_lh = 32'(a[15:0]) * 32'(b[31:16]);
    assign pp_hl = 32'(a[31:16]) * 32'(b[15:0]);
    assign pp_hh = 32'(a[31:16]) * 32'(b[31:16]);

    // signed high word = unsigned high word minus this term
    assign corr = (op == exe_pkg::MUL_MULH) ?
                  ((a[31] ? b : '0) + (b[31] ? a : '0)) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_en <= 1'b0;
            out_en <= 1'b0;
        end else begin
            mid_en <= en;
            out_en <= mid_en;
        end
    end

    always_ff @(posedge clk) begin
        mid_rd  <= rd;
        op_q    <= op;
        pp_ll_q <= pp_ll;
        pp_lh_q <= pp_lh;
        pp_hl_q <= pp_hl;
        pp_hh_q <= pp_hh;
        corr_q  <= corr;
    end

    assign sum = {pp_hh_q, pp_ll_q} + {16'b0, pp_lh_q, 16'b0} + {16'b0, pp_hl_q, 16'b0};
    assign high = sum[63:32] - corr_q;

    always_ff @(posedge clk) begin
        out_rd <= mid_rd;
        result <= (op_q == exe_pkg::MUL_MUL) ? sum[31:0] : high;
    end

    out_en_delay: assert property (@(posedge clk) disable iff (!rst_n)
        out_en == $past(mid_en))
        else $error("mul_pipe out_en is not mid_en delayed by one cycle");

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module exe_stage_tb \
    -f files.f -o exe_sim

out=$(./obj_dir/exe_sim)
echo "$out"
echo "$out" | grep -q "TEST PASS"

//--- verif/exe_stage_tb.sv
module exe_stage_tb;

    localparam int n_issue = 300;
    localparam int watchdog_time = n_issue * 4 * 3;

    logic               clk;
    logic               rst_n;
    logic               eu0_en;
    exe_pkg::unit_t     eu0_unit;
    exe_pkg::alu_op_t   eu0_alu_op;
    exe_pkg::br_op_t    eu0_br_op;
    exe_pkg::mul_op_t   eu0_mul_op;
    logic               eu0_src2_imm;
    exe_pkg::reg_addr_t eu0_rd, eu0_rj, eu0_rk;
    exe_pkg::data_t     eu0_imm;
    exe_pkg::pc_t       eu0_pc, eu0_pc_next;
    logic               eu1_en;
    exe_pkg::alu_op_t   eu1_alu_op;
    logic               eu1_src2_imm;
    exe_pkg::reg_addr_t eu1_rd, eu1_rj, eu1_rk;
    exe_pkg::data_t     eu1_imm;
    exe_pkg::data_t     data00, data01, data10, data11;
    logic               en_out0, en_out1;
    exe_pkg::reg_addr_t addr_out0, addr_out1;
    exe_pkg::data_t     data_out0, data_out1;
    logic               stall, flush, branch_taken;
    exe_pkg::pc_t       branch_pc, correct_pc_next;

    logic [15:0]        lfsr;
    exe_pkg::data_t     rf [32];
    exe_pkg::data_t     arch [32];
    int                 cycle;
    int                 mul_edge;
    exe_pkg::reg_addr_t mul_rd;
    int                 flush_edge;
    logic               any_accepted;
    int                 q_edge0[$], q_edge1[$];
    exe_pkg::reg_addr_t q_addr0[$], q_addr1[$];
    exe_pkg::data_t     q_data0[$], q_data1[$];
    int                 q_br_edge[$];
    exe_pkg::pc_t       q_br_pc[$], q_br_target[$];
    logic               q_br_taken[$];

    exe_stage exe_stage_i (.*);

    always #2 clk = ~clk;

    // register file seen by the DUT
    always_comb begin
        data00 = rf[eu0_rj];
        data01 = rf[eu0_rk];
        data10 = rf[eu1_rj];
        data11 = rf[eu1_rk];
    end

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic fail_now(input string msg);
        $display("Fail %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic exe_pkg::data_t alu_model(input exe_pkg::alu_op_t op,
                                                 input exe_pkg::data_t a, input exe_pkg::data_t b);
        case (op)
            exe_pkg::ALU_ADD:  return a + b;
            exe_pkg::ALU_SUB:  return a - b;
            exe_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exe_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            exe_pkg::ALU_AND:  return a & b;
            exe_pkg::ALU_OR:   return a | b;
            exe_pkg::ALU_XOR:  return a ^ b;
            exe_pkg::ALU_NOR:  return ~(a | b);
            exe_pkg::ALU_SLL:  return a << b[4:0];
            exe_pkg::ALU_SRL:  return a >> b[4:0];
            exe_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            default:           return b;
        endcase
    endfunction

    function automatic exe_pkg::data_t mul_model(input exe_pkg::mul_op_t op,
                                                 input exe_pkg::data_t a, input exe_pkg::data_t b);
        logic signed [63:0] sp;
        logic [63:0]        up;
        sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        up = {32'b0, a} * {32'b0, b};
        case (op)
            exe_pkg::MUL_MUL:  return up[31:0];
            exe_pkg::MUL_MULH: return sp[63:32];
            default:           return up[63:32];
        endcase
    endfunction

    task automatic branch_model(input exe_pkg::br_op_t op, input exe_pkg::pc_t pc,
                                input exe_pkg::data_t a, input exe_pkg::data_t b,
                                input exe_pkg::data_t imm, output logic taken,
                                output exe_pkg::pc_t target);
        case (op)
            exe_pkg::BR_BEQ:  taken = a == b;
            exe_pkg::BR_BNE:  taken = a != b;
            exe_pkg::BR_BLT:  taken = $signed(a) < $signed(b);
            exe_pkg::BR_BGE:  taken = $signed(a) >= $signed(b);
            exe_pkg::BR_BLTU: taken = a < b;
            exe_pkg::BR_BGEU: taken = a >= b;
            default:          taken = 1'b1;
        endcase
        if (!taken) begin
            target = pc + 32'd4;
        end else if (op == exe_pkg::BR_JIRL) begin
            target = a + imm;
        end else begin
            target = pc + imm;
        end
    endtask

    task automatic new_group();
        logic [31:0]  r;
        logic         tk;
        exe_pkg::pc_t tg;
        r = take_bits(3);
        eu0_en = r != 0;
        r = take_bits(2);
        eu0_unit = (r < 2) ? exe_pkg::UNIT_ALU : (r == 2) ? exe_pkg::UNIT_BR : exe_pkg::UNIT_MUL;
        eu0_alu_op = exe_pkg::alu_op_t'(take_bits(4) % 12);
        eu0_br_op = exe_pkg::br_op_t'(take_bits(4) % 9);
        eu0_mul_op = exe_pkg::mul_op_t'(take_bits(2) % 3);
        eu0_src2_imm = 1'(take_bits(1));
        eu0_rd = 5'(take_bits(3));
        eu0_rj = 5'(take_bits(3));
        eu0_rk = 5'(take_bits(3));
        eu0_pc = {30'(take_bits(16)), 2'b00};
        r = take_bits(10);
        eu0_imm = (eu0_unit == exe_pkg::UNIT_BR) ? {{22{r[9]}}, r[9:2], 2'b00} : take_bits(32);
        branch_model(eu0_br_op, eu0_pc, arch[eu0_rj], arch[eu0_rk], eu0_imm, tk, tg);
        // one branch in four gets a wrong prediction
        eu0_pc_next = (take_bits(2) == 0) ? tg + 32'd8 : tg;
        r = take_bits(3);
        eu1_en = r != 0;
        eu1_alu_op = exe_pkg::alu_op_t'(take_bits(4) % 12);
        eu1_src2_imm = 1'(take_bits(1));
        eu1_rd = 5'(take_bits(3));
        eu1_rj = 5'(take_bits(3));
        eu1_rk = 5'(take_bits(3));
        eu1_imm = take_bits(32);
    endtask

    // decides acceptance before the coming edge and runs the model
    task automatic accept_group(output logic hold);
        logic           stall_exp;
        logic           tk;
        logic           kill1;
        exe_pkg::pc_t   tg;
        exe_pkg::data_t a0, b0, a1, b1, r0, r1;
        stall_exp = (mul_edge == cycle) && (mul_rd != 0) &&
                    ((eu0_en && (eu0_rj == mul_rd || eu0_rk == mul_rd)) ||
                     (eu1_en && (eu1_rj == mul_rd || eu1_rk == mul_rd)));
        stall_match: assert (stall == stall_exp)
            else fail_now($sformatf("stall is %0b, expected %0b", stall, stall_exp));
        hold = stall_exp;
        if (stall_exp || flush_edge == cycle) begin
            return;
        end
        kill1 = 1'b0;
        a0 = arch[eu0_rj];
        b0 = arch[eu0_rk];
        a1 = arch[eu1_rj];
        b1 = eu1_src2_imm ? eu1_imm : arch[eu1_rk];
        if (eu0_en) begin
            any_accepted = 1'b1;
            case (eu0_unit)
                exe_pkg::UNIT_ALU: begin
                    r0 = alu_model(eu0_alu_op, a0, eu0_src2_imm ? eu0_imm : b0);
                    q_edge0.push_back(cycle + 3);
                    q_addr0.push_back(eu0_rd);
                    q_data0.push_back(r0);
                    if (eu0_rd != 0) arch[eu0_rd] = r0;
                end
                exe_pkg::UNIT_MUL: begin
                    r0 = mul_model(eu0_mul_op, a0, b0);
                    q_edge0.push_back(cycle + 3);
                    q_addr0.push_back(eu0_rd);
                    q_data0.push_back(r0);
                    if (eu0_rd != 0) arch[eu0_rd] = r0;
                    mul_edge = cycle + 1;
                    mul_rd = eu0_rd;
                end
                default: begin
                    branch_model(eu0_br_op, eu0_pc, a0, b0, eu0_imm, tk, tg);
                    q_br_edge.push_back(cycle + 2);
                    q_br_pc.push_back(eu0_pc);
                    q_br_target.push_back(tg);
                    q_br_taken.push_back(tk);
                    kill1 = tg != eu0_pc_next;
                    if (kill1) flush_edge = cycle + 1;
                    if (eu0_br_op == exe_pkg::BR_BL || eu0_br_op == exe_pkg::BR_JIRL) begin
                        q_edge0.push_back(cycle + 3);
                        q_addr0.push_back(eu0_rd);
                        q_data0.push_back(eu0_pc + 32'd4);
                        if (eu0_rd != 0) arch[eu0_rd] = eu0_pc + 32'd4;
                    end
                end
            endcase
        end
        // lane 1 is younger than lane 0 and reads the state before the pair
        if (eu1_en && !kill1) begin
            any_accepted = 1'b1;
            r1 = alu_model(eu1_alu_op, a1, b1);
            q_edge1.push_back(cycle + 3);
            q_addr1.push_back(eu1_rd);
            q_data1.push_back(r1);
            if (eu1_rd != 0) arch[eu1_rd] = r1;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            cycle = cycle + 1;
            if (!any_accepted) begin
                quiet_after_reset: assert (!en_out0 && !en_out1 && !stall && !flush)
                    else fail_now("outputs active before any instruction was accepted");
            end
            flush_check: assert (flush == (flush_edge + 1 == cycle))
                else fail_now($sformatf("flush is %0b at the wrong time", flush));
            if (q_br_edge.size() != 0 && q_br_edge[0] == cycle) begin
                taken_check: assert (branch_taken == q_br_taken[0])
                    else fail_now($sformatf("branch_taken is %0b, expected %0b",
                                            branch_taken, q_br_taken[0]));
                target_check: assert (correct_pc_next == q_br_target[0] &&
                                      branch_pc == q_br_pc[0])
                    else fail_now($sformatf("correct_pc_next %h, expected %h",
                                            correct_pc_next, q_br_target[0]));
                void'(q_br_edge.pop_front());
                void'(q_br_pc.pop_front());
                void'(q_br_target.pop_front());
                void'(q_br_taken.pop_front());
            end else begin
                taken_idle: assert (!branch_taken)
                    else fail_now("branch_taken high without a branch one cycle earlier");
            end
            if (en_out0) begin
                lane0_due: assert (q_edge0.size() != 0 && q_edge0[0] == cycle)
                    else fail_now("lane 0 result at an unexpected cycle");
                lane0_value: assert (addr_out0 == q_addr0[0] && data_out0 == q_data0[0])
                    else fail_now($sformatf("lane 0 r%0d=%h, expected r%0d=%h",
                                            addr_out0, data_out0, q_addr0[0], q_data0[0]));
                void'(q_edge0.pop_front());
                void'(q_addr0.pop_front());
                void'(q_data0.pop_front());
            end else if (q_edge0.size() != 0) begin
                lane0_missing: assert (q_edge0[0] > cycle)
                    else fail_now("lane 0 result did not appear");
            end
            if (en_out1) begin
                lane1_due: assert (q_edge1.size() != 0 && q_edge1[0] == cycle)
                    else fail_now("lane 1 result at an unexpected cycle");
                lane1_value: assert (addr_out1 == q_addr1[0] && data_out1 == q_data1[0])
                    else fail_now($sformatf("lane 1 r%0d=%h, expected r%0d=%h",
                                            addr_out1, data_out1, q_addr1[0], q_data1[0]));
                void'(q_edge1.pop_front());
                void'(q_addr1.pop_front());
                void'(q_data1.pop_front());
            end else if (q_edge1.size() != 0) begin
                lane1_missing: assert (q_edge1[0] > cycle)
                    else fail_now("lane 1 result did not appear");
            end
            // lane 1 written last as the younger one
            if (en_out0 && addr_out0 != 0) rf[addr_out0] <= data_out0;
            if (en_out1 && addr_out1 != 0) rf[addr_out1] <= data_out1;
        end
    end

    stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall)
        else fail_now("stall held for more than one cycle");

    initial begin
        #(watchdog_time);
        $display("Simulation timed out before all results were seen");
        $display("TEST FAIL");
        $fatal(1);
    end

    initial begin
        logic hold;
        clk = 1'b0;
        rst_n = 1'b0;
        lfsr = 16'd7236;
        cycle = 0;
        mul_edge = -10;
        mul_rd = '0;
        flush_edge = -10;
        any_accepted = 1'b0;
        hold = 1'b0;
        for (int i = 0; i < 32; i++) begin
            rf[i] = (i == 0) ? '0 : 32'(i) * 32'h9e37_79b9 + 32'(i << 7);
            arch[i] = rf[i];
        end
        eu0_en = 1'b0;
        eu0_unit = exe_pkg::UNIT_ALU;
        eu0_alu_op = exe_pkg::ALU_ADD;
        eu0_br_op = exe_pkg::BR_BEQ;
        eu0_mul_op = exe_pkg::MUL_MUL;
        eu0_src2_imm = 1'b0;
        eu0_rd = '0;
        eu0_rj = '0;
        eu0_rk = '0;
        eu0_imm = '0;
        eu0_pc = '0;
        eu0_pc_next = '0;
        eu1_en = 1'b0;
        eu1_alu_op = exe_pkg::ALU_ADD;
        eu1_src2_imm = 1'b0;
        eu1_rd = '0;
        eu1_rj = '0;
        eu1_rk = '0;
        eu1_imm = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        // a few idle cycles to see the outputs stay quiet
        repeat (3) @(negedge clk);
        for (int k = 0; k < n_issue; k++) begin
            if (!hold) new_group();
            #1;
            accept_group(hold);
            @(negedge clk);
        end
        eu0_en = 1'b0;
        eu1_en = 1'b0;
        while (q_edge0.size() != 0 || q_edge1.size() != 0 || q_br_edge.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- verilog/alu.sv
module alu (
    input  exe_pkg::alu_op_t op,
    input  exe_pkg::data_t   a,
    input  exe_pkg::data_t   b,
    output exe_pkg::data_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt = b[4:0];
    assign lt_signed = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            exe_pkg::ALU_ADD: begin
                result = a + b;
            end
            exe_pkg::ALU_SUB: begin
                result = a - b;
            end
            exe_pkg::ALU_SLT: begin
                result = {31'b0, lt_signed};
            end
            exe_pkg::ALU_SLTU: begin
                result = {31'b0, lt_unsigned};
            end
            exe_pkg::ALU_AND: begin
                result = a & b;
            end
            exe_pkg::ALU_OR: begin
                result = a | b;
            end
            exe_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            exe_pkg::ALU_NOR: begin
                result = ~(a | b);
            end
            exe_pkg::ALU_SLL: begin
                result = a << shamt;
            end
            exe_pkg::ALU_SRL: begin
                result = a >> shamt;
            end
            exe_pkg::ALU_SRA: begin
                result = $signed(a) >>> shamt;
            end
            // immediate is already placed in the upper bits
            exe_pkg::ALU_LUI: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- verilog/branch_unit.sv
module branch_unit (
    input  exe_pkg::br_op_t op,
    input  exe_pkg::pc_t    pc,
    input  exe_pkg::pc_t    pc_next,
    input  exe_pkg::data_t  sr0,
    input  exe_pkg::data_t  sr1,
    input  exe_pkg::data_t  imm,
    output logic            taken,
    output exe_pkg::pc_t    target,
    output logic            link_en,
    output exe_pkg::data_t  link_data,
    output logic            mispredict
);

    logic         eq;
    logic         lt_signed;
    logic         lt_unsigned;
    exe_pkg::pc_t jump_pc;
    exe_pkg::pc_t seq_pc;

    assign eq = sr0 == sr1;
    assign lt_signed = $signed(sr0) < $signed(sr1);
    assign lt_unsigned = sr0 < sr1;

    always_comb begin
        case (op)
            exe_pkg::BR_BEQ: begin
                taken = eq;
            end
            exe_pkg::BR_BNE: begin
                taken = !eq;
            end
            exe_pkg::BR_BLT: begin
                taken = lt_signed;
            end
            exe_pkg::BR_BGE: begin
                taken = !lt_signed;
            end
            exe_pkg::BR_BLTU: begin
                taken = lt_unsigned;
            end
            exe_pkg::BR_BGEU: begin
                taken = !lt_unsigned;
            end
            exe_pkg::BR_B, exe_pkg::BR_BL, exe_pkg::BR_JIRL: begin
                taken = 1'b1;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign jump_pc = (op == exe_pkg::BR_JIRL) ? sr0 + imm : pc + imm;
    assign seq_pc = pc + 32'd4;

    // target is the real next pc, sequential when not taken
    assign target = taken ? jump_pc : seq_pc;

    assign link_en = (op == exe_pkg::BR_BL) || (op == exe_pkg::BR_JIRL);
    assign link_data = pc + exe_pkg::link_offset;

    assign mispredict = target != pc_next;

endmodule

//--- verilog/exe_stage.sv
module exe_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               eu0_en,
    input  exe_pkg::unit_t     eu0_unit,
    input  exe_pkg::alu_op_t   eu0_alu_op,
    input  exe_pkg::br_op_t    eu0_br_op,
    input  exe_pkg::mul_op_t   eu0_mul_op,
    input  logic               eu0_src2_imm,
    input  exe_pkg::reg_addr_t eu0_rd,
    input  exe_pkg::reg_addr_t eu0_rj,
    input  exe_pkg::reg_addr_t eu0_rk,
    input  exe_pkg::data_t     eu0_imm,
    input  exe_pkg::pc_t       eu0_pc,
    input  exe_pkg::pc_t       eu0_pc_next,
    input  logic               eu1_en,
    input  exe_pkg::alu_op_t   eu1_alu_op,
    input  logic               eu1_src2_imm,
    input  exe_pkg::reg_addr_t eu1_rd,
    input  exe_pkg::reg_addr_t eu1_rj,
    input  exe_pkg::reg_addr_t eu1_rk,
    input  exe_pkg::data_t     eu1_imm,
    input  exe_pkg::data_t     data00,
    input  exe_pkg::data_t     data01,
    input  exe_pkg::data_t     data10,
    input  exe_pkg::data_t     data11,
    output logic               en_out0,
    output exe_pkg::reg_addr_t addr_out0,
    output exe_pkg::data_t     data_out0,
    output logic               en_out1,
    output exe_pkg::reg_addr_t addr_out1,
    output exe_pkg::data_t     data_out1,
    output logic               stall,
    output logic               flush,
    output exe_pkg::pc_t       branch_pc,
    output exe_pkg::pc_t       correct_pc_next,
    output logic               branch_taken
);

    exe_pkg::data_t     eu0_sr0, eu0_sr1, eu1_sr0, eu1_sr1;
    exe_pkg::data_t     eu0_b, eu1_b, alu0_result, alu1_result;
    logic               br_taken, br_link_en, br_mispredict;
    exe_pkg::pc_t       br_target;
    exe_pkg::data_t     br_link_data;
    logic               mul_mid_en, mul_out_en;
    exe_pkg::reg_addr_t mul_mid_rd, mul_out_rd;
    exe_pkg::data_t     mul_result;
    logic               lane0_go, lane1_go, br_go, kill1;
    logic               mid_en0, mid_en1, out_en0;
    exe_pkg::reg_addr_t mid_rd0, mid_rd1, out_rd0;
    exe_pkg::data_t     mid_data0, mid_data1, out_data0;

    // issue group is dropped while stalled and in the cycle after a mispredict
    assign lane0_go = eu0_en && !stall && !flush;
    assign br_go = lane0_go && (eu0_unit == exe_pkg::UNIT_BR);
    assign kill1 = br_go && br_mispredict;
    assign lane1_go = eu1_en && !stall && !flush && !kill1;

    assign eu0_b = eu0_src2_imm ? eu0_imm : eu0_sr1;
    assign eu1_b = eu1_src2_imm ? eu1_imm : eu1_sr1;

    operand_forward operand_forward_i (
        .eu0_rj(eu0_rj), .eu0_rk(eu0_rk), .eu1_rj(eu1_rj), .eu1_rk(eu1_rk),
        .data00(data00), .data01(data01), .data10(data10), .data11(data11),
        .mid_en0(mid_en0), .mid_rd0(mid_rd0), .mid_data0(mid_data0),
        .mid_en1(mid_en1), .mid_rd1(mid_rd1), .mid_data1(mid_data1),
        .out_en0(en_out0), .out_rd0(addr_out0), .out_data0(data_out0),
        .out_en1(en_out1), .out_rd1(addr_out1), .out_data1(data_out1),
        .eu0_sr0(eu0_sr0), .eu0_sr1(eu0_sr1), .eu1_sr0(eu1_sr0), .eu1_sr1(eu1_sr1)
    );

    issue_hazard issue_hazard_i (
        .eu0_en(eu0_en), .eu1_en(eu1_en),
        .eu0_rj(eu0_rj), .eu0_rk(eu0_rk), .eu1_rj(eu1_rj), .eu1_rk(eu1_rk),
        .mul_mid_en(mul_mid_en), .mul_mid_rd(mul_mid_rd),
        .stall(stall)
    );

    alu alu0_i (.op(eu0_alu_op), .a(eu0_sr0), .b(eu0_b), .result(alu0_result));
    alu alu1_i (.op(eu1_alu_op), .a(eu1_sr0), .b(eu1_b), .result(alu1_result));

    branch_unit branch_unit_i (
        .op(eu0_br_op), .pc(eu0_pc), .pc_next(eu0_pc_next),
        .sr0(eu0_sr0), .sr1(eu0_sr1), .imm(eu0_imm),
        .taken(br_taken), .target(br_target), .link_en(br_link_en),
        .link_data(br_link_data), .mispredict(br_mispredict)
    );

    mul_pipe mul_pipe_i (
        .clk(clk), .rst_n(rst_n),
        .en(lane0_go && (eu0_unit == exe_pkg::UNIT_MUL)),
        .op(eu0_mul_op), .rd(eu0_rd), .a(eu0_sr0), .b(eu0_sr1),
        .mid_en(mul_mid_en), .mid_rd(mul_mid_rd),
        .out_en(mul_out_en), .out_rd(mul_out_rd), .result(mul_result)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_en0      <= 1'b0;
            mid_en1      <= 1'b0;
            out_en0      <= 1'b0;
            en_out1      <= 1'b0;
            flush        <= 1'b0;
            branch_taken <= 1'b0;
        end else begin
            // branches without link retire nothing
            mid_en0      <= lane0_go && ((eu0_unit == exe_pkg::UNIT_ALU) ||
                                         (eu0_unit == exe_pkg::UNIT_BR && br_link_en));
            mid_en1      <= lane1_go;
            out_en0      <= mid_en0;
            en_out1      <= mid_en1;
            flush        <= kill1;
            branch_taken <= br_go && br_taken;
        end
    end

    always_ff @(posedge clk) begin
        mid_rd0   <= eu0_rd;
        mid_data0 <= (eu0_unit == exe_pkg::UNIT_BR) ? br_link_data : alu0_result;
        mid_rd1   <= eu1_rd;
        mid_data1 <= alu1_result;
        out_rd0   <= mid_rd0;
        out_data0 <= mid_data0;
        addr_out1 <= mid_rd1;
        data_out1 <= mid_data1;
        if (br_go) begin
            branch_pc       <= eu0_pc;
            correct_pc_next <= br_target;
        end
    end

    // lane 0 writeback, at most one source per cycle
    assign en_out0 = out_en0 || mul_out_en;
    assign addr_out0 = mul_out_en ? mul_out_rd : out_rd0;
    assign data_out0 = mul_out_en ? mul_result : out_data0;

    lane0_origin: assert property (@(posedge clk) disable iff (!rst_n)
        en_out0 |-> $past(lane0_go, 2))
        else $error("en_out0 without a lane 0 instruction two cycles earlier");

    flush_single: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !flush)
        else $error("flush held for two cycles");

endmodule

//--- verilog/issue_hazard.sv
module issue_hazard (
    input  logic               eu0_en,
    input  logic               eu1_en,
    input  exe_pkg::reg_addr_t eu0_rj,
    input  exe_pkg::reg_addr_t eu0_rk,
    input  exe_pkg::reg_addr_t eu1_rj,
    input  exe_pkg::reg_addr_t eu1_rk,
    input  logic               mul_mid_en,
    input  exe_pkg::reg_addr_t mul_mid_rd,
    output logic               stall
);

    logic mul_live;
    logic eu0_dep;
    logic eu1_dep;

    // multiply result is not ready until the out stage
    assign mul_live = mul_mid_en && (mul_mid_rd != '0);
    assign eu0_dep = eu0_en && (eu0_rj == mul_mid_rd || eu0_rk == mul_mid_rd);
    assign eu1_dep = eu1_en && (eu1_rj == mul_mid_rd || eu1_rk == mul_mid_rd);

    assign stall = mul_live && (eu0_dep || eu1_dep);

    always_comb begin
        stall_needs_mul: assert (!stall || mul_mid_en)
            else $error("stall raised without a multiply in the mid stage");
    end

endmodule

//--- verilog/operand_forward.sv
module operand_forward (
    input  exe_pkg::reg_addr_t eu0_rj,
    input  exe_pkg::reg_addr_t eu0_rk,
    input  exe_pkg::reg_addr_t eu1_rj,
    input  exe_pkg::reg_addr_t eu1_rk,
    input  exe_pkg::data_t     data00,
    input  exe_pkg::data_t     data01,
    input  exe_pkg::data_t     data10,
    input  exe_pkg::data_t     data11,
    input  logic               mid_en0,
    input  exe_pkg::reg_addr_t mid_rd0,
    input  exe_pkg::data_t     mid_data0,
    input  logic               mid_en1,
    input  exe_pkg::reg_addr_t mid_rd1,
    input  exe_pkg::data_t     mid_data1,
    input  logic               out_en0,
    input  exe_pkg::reg_addr_t out_rd0,
    input  exe_pkg::data_t     out_data0,
    input  logic               out_en1,
    input  exe_pkg::reg_addr_t out_rd1,
    input  exe_pkg::data_t     out_data1,
    output exe_pkg::data_t     eu0_sr0,
    output exe_pkg::data_t     eu0_sr1,
    output exe_pkg::data_t     eu1_sr0,
    output exe_pkg::data_t     eu1_sr1
);

    // youngest producer first, lane 1 is younger within a stage
    function automatic exe_pkg::data_t pick(input exe_pkg::reg_addr_t addr,
                                            input exe_pkg::data_t rf_data);
        exe_pkg::data_t value;
        if (addr == '0) begin
            value = '0;
        end else if (mid_en1 && mid_rd1 == addr) begin
            value = mid_data1;
        end else if (mid_en0 && mid_rd0 == addr) begin
            value = mid_data0;
        end else if (out_en1 && out_rd1 == addr) begin
            value = out_data1;
        end else if (out_en0 && out_rd0 == addr) begin
            value = out_data0;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    always_comb begin
        eu0_sr0 = pick(eu0_rj, data00);
        eu0_sr1 = pick(eu0_rk, data01);
        eu1_sr0 = pick(eu1_rj, data10);
        eu1_sr1 = pick(eu1_rk, data11);
    end

endmodule
